// File: Makefile
VERILATOR ?= verilator
TOP       ?= arithmetic_encoder_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o V$(TOP)

# Passes only when the testbench prints its pass line
run: build
	@out="$$($(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation passed"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: logic/arithmetic_encoder.sv
`timescale 1ns/10ps
`default_nettype none

module arithmetic_encoder #(
  parameter int SYMBOL_WIDTH = 4  // Up to 16 symbols
) (
  input  logic                           general_clk,
  input  logic                           reset,
  input  logic                           in_valid,
  input  logic [ec_pkg::RANGE_WIDTH-1:0] fl,
  input  logic [ec_pkg::RANGE_WIDTH-1:0] fh,
  input  logic [SYMBOL_WIDTH-1:0]        symbol,
  input  logic [SYMBOL_WIDTH:0]          nsyms,
  output logic                           out_valid,
  output logic [ec_pkg::RANGE_WIDTH-1:0] range_out,
  output logic [ec_pkg::LOW_WIDTH-1:0]   low_out,
  output logic [ec_pkg::CNT_WIDTH-1:0]   cnt_out,
  output logic [ec_pkg::RANGE_WIDTH-1:0] out_word_1,
  output logic [ec_pkg::RANGE_WIDTH-1:0] out_word_2,
  output logic [1:0]                     out_count
);

  // --------------------------------------------------
  // Stage buses

  ec_scaled_if #(.SYMBOL_WIDTH(SYMBOL_WIDTH)) scaled_bus ();
  ec_renorm_if renorm_bus ();

  // --------------------------------------------------
  // Three-stage pipeline, one symbol per cycle

  ec_prob_scale #(
    .SYMBOL_WIDTH (SYMBOL_WIDTH)
  ) u_prob_scale (
    .general_clk (general_clk),
    .reset       (reset),
    .in_valid    (in_valid),
    .fl          (fl),
    .fh          (fh),
    .symbol      (symbol),
    .nsyms       (nsyms),
    .scaled      (scaled_bus)
  );

  ec_range_update u_range_update (
    .general_clk (general_clk),
    .reset       (reset),
    .scaled      (scaled_bus),
    .renorm      (renorm_bus)
  );

  ec_low_update u_low_update (
    .general_clk (general_clk),
    .reset       (reset),
    .renorm      (renorm_bus),
    .out_valid   (out_valid),
    .range_out   (range_out),   // State after the symbol
    .low_out     (low_out),
    .cnt_out     (cnt_out),
    .out_word_1  (out_word_1),  // Pre-carry words, carries resolved downstream
    .out_word_2  (out_word_2),
    .out_count   (out_count)
  );

endmodule

`default_nettype wire

// File: logic/ec_interfaces.sv
`timescale 1ns/10ps
`default_nettype none

// Scaled probabilities, stage 1 to stage 2
interface ec_scaled_if #(
  parameter int SYMBOL_WIDTH = 4
);
  import ec_pkg::*;

  logic                                  valid;
  logic [FREQ_WIDTH-1:0]                 fl_scaled;
  logic [FREQ_WIDTH-1:0]                 fh_scaled;
  logic [SYMBOL_WIDTH+MIN_PROB_BITS:0]   u_offset;  // MIN_PROB * (nsyms - s)
  logic [SYMBOL_WIDTH+MIN_PROB_BITS:0]   v_offset;  // One step below u_offset
  logic                                  first_symbol;

  modport producer (output valid, fl_scaled, fh_scaled, u_offset, v_offset,
                    first_symbol);
  modport consumer (input valid, fl_scaled, fh_scaled, u_offset, v_offset,
                    first_symbol);

endinterface

// Renormalization results, stage 2 to stage 3
interface ec_renorm_if;
  import ec_pkg::*;

  logic                   valid;
  logic [D_WIDTH-1:0]     d;           // Leading zeros of new range
  logic [RANGE_WIDTH-1:0] low_add;
  logic [RANGE_WIDTH-1:0] range_norm;

  modport producer (output valid, d, low_add, range_norm);
  modport consumer (input valid, d, low_add, range_norm);

endinterface

`default_nettype wire

// File: logic/ec_low_update.sv
`timescale 1ns/10ps
`default_nettype none

module ec_low_update (
  input  logic                           general_clk,
  input  logic                           reset,
  ec_renorm_if.consumer                  renorm,
  output logic                           out_valid,
  output logic [ec_pkg::RANGE_WIDTH-1:0] range_out,
  output logic [ec_pkg::LOW_WIDTH-1:0]   low_out,
  output logic [ec_pkg::CNT_WIDTH-1:0]   cnt_out,
  output logic [ec_pkg::RANGE_WIDTH-1:0] out_word_1,
  output logic [ec_pkg::RANGE_WIDTH-1:0] out_word_2,
  output logic [1:0]                     out_count
);
  import ec_pkg::*;

  localparam int SW = CNT_WIDTH + 2;  // Room for count plus shift

  localparam logic signed [SW-1:0] C_BASE = SW'(RANGE_WIDTH);
  localparam logic signed [SW-1:0] STEP   = SW'(LOW_WIDTH - RANGE_WIDTH);
  localparam logic signed [SW-1:0] C_DROP = SW'(LOW_WIDTH);

  logic [LOW_WIDTH-1:0]   low_sum;
  logic [LOW_WIDTH-1:0]   low_rem;
  logic [LOW_WIDTH-1:0]   low_next;
  logic signed [SW-1:0]   s;
  logic signed [SW-1:0]   c;
  logic [CNT_WIDTH-1:0]   cnt_next;
  logic [RANGE_WIDTH-1:0] word_1;
  logic [RANGE_WIDTH-1:0] word_2;
  logic [RANGE_WIDTH-1:0] tail_word;
  logic [1:0]             word_count;

  // --------------------------------------------------
  // Low update and word emission

  always_comb begin
    low_sum    = low_out + LOW_WIDTH'(renorm.low_add);
    s          = $signed(cnt_out) + $signed({1'b0, renorm.d});
    c          = $signed(cnt_out) + C_BASE;
    low_rem    = low_sum;
    word_1     = '0;
    word_2     = '0;
    tail_word  = '0;
    word_count = 2'd0;
    cnt_next   = s[CNT_WIDTH-1:0];  // Nothing emitted while s is negative

    if (!s[SW-1]) begin
      word_count = 2'd1;
      if (s >= STEP) begin
        // Enough pending bits for an extra word
        word_1     = RANGE_WIDTH'(low_rem >> c);
        low_rem    = low_rem & ~({LOW_WIDTH{1'b1}} << c);
        c          = c - STEP;
        word_count = 2'd2;
      end
      tail_word = RANGE_WIDTH'(low_rem >> c);
      low_rem   = low_rem & ~({LOW_WIDTH{1'b1}} << c);
      if (word_count == 2'd2) begin
        word_2 = tail_word;
      end else begin
        word_1 = tail_word;
      end
      cnt_next = CNT_WIDTH'(c + $signed({1'b0, renorm.d}) - C_DROP);
    end

    low_next = low_rem << renorm.d;
  end

  // --------------------------------------------------
  // State and output registers

  always_ff @(posedge general_clk) begin
    if (reset) begin
      out_valid <= 1'b0;
      out_count <= 2'd0;
      range_out <= RANGE_INIT;
      low_out   <= '0;
      cnt_out   <= CNT_INIT;
    end else begin
      out_valid <= renorm.valid;
      out_count <= renorm.valid ? word_count : 2'd0;
      if (renorm.valid) begin
        range_out <= renorm.range_norm;  // Straight from stage 2
        low_out   <= low_next;
        cnt_out   <= cnt_next;
      end
    end
  end

  always_ff @(posedge general_clk) begin
    if (renorm.valid) begin
      out_word_1 <= word_1;
      out_word_2 <= word_2;
    end
  end

endmodule

`default_nettype wire

// File: logic/ec_pkg.sv
`default_nettype none

package ec_pkg;

  // --------------------------------------------------
  // Datapath widths
  localparam int RANGE_WIDTH = 16;  // Range, frequencies, emitted words
  localparam int LOW_WIDTH   = 24;
  localparam int CNT_WIDTH   = 5;   // Signed pending-bit counter

  // --------------------------------------------------
  // Probability model
  localparam int PROB_SHIFT = 6;
  localparam int MIN_PROB   = 4;    // Floor per remaining symbol

  localparam int FREQ_WIDTH    = RANGE_WIDTH - PROB_SHIFT;  // Scaled frequency
  localparam int MIN_PROB_BITS = $clog2(MIN_PROB + 1);
  localparam int D_WIDTH       = $clog2(RANGE_WIDTH);      // Renorm shift

  // State after reset
  localparam logic signed [CNT_WIDTH-1:0] CNT_INIT   = CNT_WIDTH'(-9);
  localparam logic [RANGE_WIDTH-1:0]      RANGE_INIT = RANGE_WIDTH'(32768);

endpackage

`default_nettype wire

// File: logic/ec_prob_scale.sv
`timescale 1ns/10ps
`default_nettype none

module ec_prob_scale #(
  parameter int SYMBOL_WIDTH = 4
) (
  input  logic                          general_clk,
  input  logic                          reset,
  input  logic                          in_valid,
  input  logic [ec_pkg::RANGE_WIDTH-1:0] fl,
  input  logic [ec_pkg::RANGE_WIDTH-1:0] fh,
  input  logic [SYMBOL_WIDTH-1:0]       symbol,
  input  logic [SYMBOL_WIDTH:0]         nsyms,
  ec_scaled_if.producer                 scaled
);
  import ec_pkg::*;

  localparam int OFFSET_WIDTH = SYMBOL_WIDTH + MIN_PROB_BITS + 1;

  logic [SYMBOL_WIDTH:0]   remaining;
  logic [OFFSET_WIDTH-1:0] u_offset;
  logic [OFFSET_WIDTH-1:0] v_offset;

  // --------------------------------------------------
  // Minimum-probability offsets

  // Symbols from this one to the end of the alphabet
  assign remaining = nsyms - {1'b0, symbol};

  assign u_offset = OFFSET_WIDTH'(remaining) * OFFSET_WIDTH'(MIN_PROB);
  assign v_offset = u_offset - OFFSET_WIDTH'(MIN_PROB);  // One symbol fewer

  // --------------------------------------------------
  // Stage register

  always_ff @(posedge general_clk) begin
    if (reset) begin
      scaled.valid <= 1'b0;
    end else begin
      scaled.valid <= in_valid;
    end
  end

  always_ff @(posedge general_clk) begin
    if (in_valid) begin
      scaled.fl_scaled    <= fl[RANGE_WIDTH-1:PROB_SHIFT];
      scaled.fh_scaled    <= fh[RANGE_WIDTH-1:PROB_SHIFT];
      scaled.u_offset     <= u_offset;
      scaled.v_offset     <= v_offset;
      // Lower bound at full scale, so u takes the whole range
      scaled.first_symbol <= fl[RANGE_WIDTH-1];
    end
  end

endmodule

`default_nettype wire

// File: logic/ec_range_update.sv
`timescale 1ns/10ps
`default_nettype none

module ec_range_update (
  input  logic          general_clk,
  input  logic          reset,
  ec_scaled_if.consumer scaled,
  ec_renorm_if.producer renorm
);
  import ec_pkg::*;

  localparam int PROD_WIDTH = FREQ_WIDTH + 8;  // Top byte of range times frequency

  logic [RANGE_WIDTH-1:0] range_q;
  logic [7:0]             range_top;
  logic [PROD_WIDTH-1:0]  u_prod;
  logic [PROD_WIDTH-1:0]  v_prod;
  logic [RANGE_WIDTH-1:0] u;
  logic [RANGE_WIDTH-1:0] v;
  logic [RANGE_WIDTH-1:0] range_new;
  logic [RANGE_WIDTH-1:0] range_shifted;
  logic [RANGE_WIDTH-1:0] low_add;
  logic [D_WIDTH-1:0]     lz;

  // --------------------------------------------------
  // Interval split

  assign range_top = range_q[RANGE_WIDTH-1 -: 8];

  assign u_prod = PROD_WIDTH'(range_top) * PROD_WIDTH'(scaled.fl_scaled);
  assign v_prod = PROD_WIDTH'(range_top) * PROD_WIDTH'(scaled.fh_scaled);

  // Products are halved before the offset
  assign v = RANGE_WIDTH'(v_prod >> 1) + RANGE_WIDTH'(scaled.v_offset);
  assign u = scaled.first_symbol ? range_q
                                 : RANGE_WIDTH'(u_prod >> 1) + RANGE_WIDTH'(scaled.u_offset);

  assign range_new = u - v;
  assign low_add   = range_q - u;  // Part of the interval below the symbol

  // --------------------------------------------------
  // Renormalization shift

  // Highest set bit wins, so scan upwards
  always_comb begin
    lz = '0;
    for (int i = 0; i < RANGE_WIDTH; i++) begin
      if (range_new[i]) begin
        lz = D_WIDTH'(RANGE_WIDTH - 1 - i);
      end
    end
  end

  assign range_shifted = range_new << lz;

  // --------------------------------------------------
  // Range feedback and stage register

  always_ff @(posedge general_clk) begin
    if (reset) begin
      range_q      <= RANGE_INIT;
      renorm.valid <= 1'b0;
    end else begin
      renorm.valid <= scaled.valid;
      if (scaled.valid) begin
        range_q <= range_shifted;  // Next symbol sees it at once
      end
    end
  end

  always_ff @(posedge general_clk) begin
    if (scaled.valid) begin
      renorm.d          <= lz;
      renorm.low_add    <= low_add;
      renorm.range_norm <= range_shifted;
    end
  end

endmodule

`default_nettype wire

// File: sources.f
logic/ec_pkg.sv
logic/ec_interfaces.sv
logic/ec_prob_scale.sv
logic/ec_range_update.sv
logic/ec_low_update.sv
logic/arithmetic_encoder.sv
test/arithmetic_encoder_properties.sv
test/arithmetic_encoder_tb.sv

// File: test/arithmetic_encoder_properties.sv
`timescale 1ns/10ps
`default_nettype none

module arithmetic_encoder_properties (
  input logic                           general_clk,
  input logic                           reset,
  input logic                           in_valid,
  input logic                           out_valid,
  input logic [ec_pkg::RANGE_WIDTH-1:0] range_out,
  input logic [1:0]                     out_count
);

  // Three stage registers between input and output
  latency_fixed: assert property (@(posedge general_clk) disable iff (reset)
    out_valid == $past(in_valid, 3))
    else $error("out_valid does not follow in_valid by three cycles");

  count_in_range: assert property (@(posedge general_clk) disable iff (reset)
    out_count != 2'd3)
    else $error("out_count reached three");

  range_normalized: assert property (@(posedge general_clk) disable iff (reset)
    out_valid |-> range_out[ec_pkg::RANGE_WIDTH-1])
    else $error("range_out not normalized on a valid result");

  reset_clears_valid: assert property (@(posedge general_clk)
    reset |=> !out_valid)
    else $error("out_valid high during reset");

endmodule

bind arithmetic_encoder arithmetic_encoder_properties props (
  .general_clk (general_clk),
  .reset       (reset),
  .in_valid    (in_valid),
  .out_valid   (out_valid),
  .range_out   (range_out),
  .out_count   (out_count)
);

`default_nettype wire

// File: test/arithmetic_encoder_tb.sv
`timescale 1ns/10ps
`default_nettype none

module arithmetic_encoder_tb;

  typedef struct packed {
    logic [15:0] range;
    logic [23:0] low;
    logic [4:0]  cnt;
    logic [15:0] word_1;
    logic [15:0] word_2;
    logic [1:0]  count;
  } result_t;

  localparam int STREAM_LEN     = 200;
  localparam int NARROW_LEN     = 64;
  localparam int TOTAL_SYMBOLS  = 3 + 2 * STREAM_LEN + NARROW_LEN;
  localparam int TIMEOUT_CYCLES = 2 * TOTAL_SYMBOLS + 100;

  logic        general_clk = 1'b0;
  logic        reset;
  logic        in_valid;
  logic [15:0] fl;
  logic [15:0] fh;
  logic [3:0]  symbol;
  logic [4:0]  nsyms;
  logic        out_valid;
  logic [15:0] range_out;
  logic [23:0] low_out;
  logic [4:0]  cnt_out;
  logic [15:0] out_word_1;
  logic [15:0] out_word_2;
  logic [1:0]  out_count;

  result_t     expected[$];
  result_t     last;        // State the outputs should hold
  result_t     head;
  result_t     stream_end;
  int          m_range;
  int          m_low;
  int          m_cnt;
  int          stim[STREAM_LEN][3];  // Symbol, fl, fh
  int          cycle_count = 0;
  int          two_word_hits = 0;
  logic [15:0] lfsr_state = 16'd13501;

  arithmetic_encoder #(.SYMBOL_WIDTH(4)) dut (.*);

  always #4 general_clk = ~general_clk;

  always @(posedge general_clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: run exceeded %0d cycles", TIMEOUT_CYCLES);
      fail_run();
    end
  end

  // --------------------------------------------------
  // Helpers

  task automatic fail_run();
    $display("Simulation failed");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] want);
    if (actual !== want) begin
      $display("MISMATCH %s: got %h, expected %h", name, actual, want);
      fail_run();
    end
  endtask

  // x^16 + x^14 + x^13 + x^11 + 1, one step per bit
  function automatic logic [15:0] random_bits(input int n);
    logic [15:0] value;
    logic        fb;
    value = '0;
    for (int i = 0; i < n; i++) begin
      fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
      lfsr_state = {lfsr_state[14:0], fb};
      value      = {value[14:0], fb};
    end
    return value;
  endfunction

  // Reference model of the range and low updates, eight-symbol alphabet
  task automatic model_symbol(input int sym, input int fl_v, input int fh_v);
    int      r8;
    int      u;
    int      v;
    int      rng;
    int      d;
    int      s;
    int      c;
    result_t e;
    r8  = m_range >> 8;
    u   = (fl_v >= 32768) ? m_range : ((r8 * (fl_v >> 6)) >> 1) + 4 * (8 - sym);
    v   = ((r8 * (fh_v >> 6)) >> 1) + 4 * (7 - sym);
    rng = (u - v) & 'hffff;
    d   = 0;
    while (d < 15 && ((rng >> (15 - d)) & 1) == 0) begin
      d++;
    end
    m_low   = (m_low + ((m_range - u) & 'hffff)) & 'hffffff;
    m_range = (rng << d) & 'hffff;
    e       = '0;
    s       = m_cnt + d;
    if (s >= 0) begin
      c       = m_cnt + 16;
      e.count = (s >= 8) ? 2'd2 : 2'd1;
      e.word_1 = 16'(m_low >> c);
      if (s >= 8) begin
        m_low    = m_low & ((1 << c) - 1);
        c        = c - 8;
        e.word_2 = 16'(m_low >> c);  // Second word of the pair
      end
      m_low = m_low & ((1 << c) - 1);
      s     = c + d - 24;
    end
    m_cnt   = s;
    m_low   = (m_low << d) & 'hffffff;
    e.range = 16'(m_range);
    e.low   = 24'(m_low);
    e.cnt   = 5'(m_cnt);
    expected.push_back(e);
  endtask

  task automatic send_symbol(input int sym, input int fl_v, input int fh_v);
    @(posedge general_clk);
    in_valid <= 1'b1;
    symbol   <= 4'(sym);
    fl       <= 16'(fl_v);
    fh       <= 16'(fh_v);
    model_symbol(sym, fl_v, fh_v);
  endtask

  task automatic idle_cycle();
    @(posedge general_clk);
    in_valid <= 1'b0;
  endtask

  task automatic drain_pipeline();
    idle_cycle();
    while (expected.size() != 0) begin
      @(posedge general_clk);
    end
    @(posedge general_clk);
  endtask

  task automatic reset_dut();
    @(posedge general_clk);
    reset    <= 1'b1;
    in_valid <= 1'b0;
    repeat (16) @(posedge general_clk);
    reset   <= 1'b0;
    m_range = 32768;
    m_low   = 0;
    m_cnt   = -9;
    expected.delete();
  endtask

  // --------------------------------------------------
  // Output checker, half a cycle after each edge

  always @(negedge general_clk) begin
    if (reset) begin
      last       = '0;
      last.range = 16'h8000;
      last.cnt   = 5'h17;  // Minus 9
    end else begin
      if (out_valid) begin
        if (expected.size() == 0) begin
          $display("Output valid arrived with no symbol outstanding");
          fail_run();
        end else begin
          head = expected.pop_front();
          check_value("out_word_1", 32'(out_word_1), 32'(head.word_1));
          check_value("out_word_2", 32'(out_word_2), 32'(head.word_2));
          check_value("out_count", 32'(out_count), 32'(head.count));
          if (out_count == 2'd2) two_word_hits = two_word_hits + 1;
          last = head;
        end
      end
      check_value("range_out", 32'(range_out), 32'(last.range));
      check_value("low_out", 32'(low_out), 32'(last.low));
      check_value("cnt_out", 32'(cnt_out), 32'(last.cnt));
    end
  end

  // --------------------------------------------------
  // Directed tests

  task automatic verify_reset_state();
    @(negedge general_clk);
    check_value("out_valid", 32'(out_valid), 32'd0);
    check_value("out_count", 32'(out_count), 32'd0);
    check_value("range_out", 32'(range_out), 32'h8000);
    check_value("low_out", 32'(low_out), 32'd0);
    check_value("cnt_out", 32'(cnt_out), 32'h17);
  endtask

  task automatic one_symbol_latency(input int sym, input int fl_v, input int fh_v);
    send_symbol(sym, fl_v, fh_v);
    idle_cycle();
    @(posedge general_clk);
    @(negedge general_clk);
    check_value("out_valid", 32'(out_valid), 32'd0);  // Still in stage 3
    @(negedge general_clk);
    check_value("out_valid", 32'(out_valid), 32'd1);
    drain_pipeline();
  endtask

  task automatic make_stream();
    for (int i = 0; i < STREAM_LEN; i++) begin
      stim[i][0] = int'(random_bits(3));
      stim[i][1] = (stim[i][0] == 0) ? 32768 : int'(random_bits(15));
      stim[i][2] = (stim[i][0] == 7) ? 0 : (int'(random_bits(15)) * stim[i][1]) >> 15;
    end
  endtask

  task automatic stream_replay(input bit gaps);
    for (int i = 0; i < STREAM_LEN; i++) begin
      send_symbol(stim[i][0], stim[i][1], stim[i][2]);
      if (gaps && random_bits(1) != 16'd0) idle_cycle();
    end
    drain_pipeline();
  endtask

  // Same symbols as the back-to-back run, with idle cycles in between
  task automatic gapped_stream_run();
    reset_dut();
    stream_replay(1'b1);
    @(negedge general_clk);
    check_value("range_out", 32'(range_out), 32'(stream_end.range));
    check_value("low_out", 32'(low_out), 32'(stream_end.low));
    check_value("cnt_out", 32'(cnt_out), 32'(stream_end.cnt));
  endtask

  // Narrow intervals force large shifts
  task automatic narrow_interval_run();
    int fl_v;
    int sym_v;
    two_word_hits = 0;
    for (int i = 0; i < NARROW_LEN; i++) begin
      sym_v = 1 + int'(random_bits(2));
      fl_v  = 4096 + int'(random_bits(14));
      send_symbol(sym_v, fl_v, fl_v - int'(random_bits(5)));
    end
    drain_pipeline();
    if (two_word_hits == 0) begin
      $display("No symbol in the narrow-interval run emitted two words");
      fail_run();
    end
  endtask

  initial begin
    reset    = 1'b1;
    in_valid = 1'b0;
    fl       = '0;
    fh       = '0;
    symbol   = '0;
    nsyms    = 5'd8;
    reset_dut();
    verify_reset_state();
    one_symbol_latency(3, 20000, 12000);
    one_symbol_latency(0, 32768, 24000);
    one_symbol_latency(7, 3000, 0);
    make_stream();
    reset_dut();
    stream_replay(1'b0);
    stream_end = last;
    gapped_stream_run();
    narrow_interval_run();
    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire
